/* dv/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input logic              clk,
    input logic              reset,
    input cpu_pkg::mem_cmd_e mem_cmd,
    input logic              halted
);
    import cpu_pkg::*;

    reset_quiet: assert property (@(posedge clk) reset |-> mem_cmd == MEM_NONE)
        else $error("memory command issued during reset");

    // S_RESET takes one cycle before the first fetch
    first_fetch: assert property (@(posedge clk) $fell(reset) |=> mem_cmd == MEM_READ)
        else $error("first command after reset is not a read");

    legal_cmd: assert property (@(posedge clk) mem_cmd != 2'b11)
        else $error("memory command uses the unused code");

    halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted dropped without reset");

    halt_no_write: assert property (@(posedge clk) halted |-> mem_cmd != MEM_WRITE)
        else $error("memory write while halted");

endmodule

bind cpu cpu_checker u_checker (
    .clk     (clk),
    .reset   (reset),
    .mem_cmd (mem_cmd),
    .halted  (halted)
);

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int PROG_LEN        = 60;
    localparam int RESET_CYCLES    = 10;
    localparam int CLK_PERIOD      = 4;
    localparam int WATCHDOG_MARGIN = 200;
    // sign-extends to a base whose low nine bits are 384 in the upper half
    localparam logic [7:0] DATA_BASE = 8'h80;

    logic      clk;
    logic      reset;
    word_t     read_data;
    mem_cmd_e  mem_cmd;
    mem_addr_t mem_addr;
    word_t     write_data;
    logic      n;
    logic      v;
    logic      z;
    logic      halted;

    word_t     mem [1 << `ADDR_WIDTH];
    word_t     model_mem [1 << `ADDR_WIDTH];
    word_t     model_regs [`REG_COUNT];
    status_t   model_flags;
    mem_addr_t exp_fetch [$];
    mem_addr_t exp_store_addr [$];
    word_t     exp_store_data [$];
    logic      fetch_active;

    cpu UUT (
        .clk        (clk),
        .reset      (reset),
        .read_data  (read_data),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .n          (n),
        .v          (v),
        .z          (z),
        .halted     (halted)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t shift_word(word_t w, logic [1:0] sh);
        case (sh)
            2'b01:   return {w[14:0], 1'b0};
            2'b10:   return {1'b0, w[15:1]};
            2'b11:   return {w[15], w[15:1]};
            default: return w;
        endcase
    endfunction

    function automatic word_t fill_word(int addr);
        mem_addr_t a;
        a = mem_addr_t'(addr);
        return 16'hA5C3 ^ {a[6:0], a};
    endfunction

    function automatic word_t random_inst(int idx);
        logic [2:0] rd;
        logic [2:0] rn;
        logic [2:0] rm;
        logic [1:0] sh;
        logic [1:0] op;
        logic [4:0] off5;
        int         kind;
        int         span;
        // r7 holds the data base and is never written
        rd   = 3'($urandom_range(`REG_COUNT - 2));
        rn   = 3'($urandom_range(`REG_COUNT - 1));
        rm   = 3'($urandom_range(`REG_COUNT - 1));
        sh   = 2'($urandom_range(3));
        op   = 2'($urandom_range(3));
        off5 = 5'($urandom_range(31));
        kind = int'($urandom_range(6));
        span = PROG_LEN - 2 - idx;
        case (kind)
            0:       return {3'b110, 2'b10, rd, 8'($urandom_range(255))};
            1:       return {3'b110, 2'b00, rn, rd, sh, rm};
            2:       return {3'b101, op, rn, rd, sh, rm};
            3:       return {3'b011, 2'b00, 3'd7, rd, off5};
            4, 5:    return {3'b100, 2'b00, 3'd7, rn, off5};
            // forward only and never past the final halt
            default: return {3'b001, 2'b00, 3'($urandom_range(4)),
                             8'($urandom_range(span < 3 ? span : 3))};
        endcase
    endfunction

    task automatic build_program();
        for (int a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            mem[a] = fill_word(a);
        end
        for (int r = 0; r < `REG_COUNT - 1; r++) begin
            mem[r] = {3'b110, 2'b10, 3'(r), 8'($urandom_range(255))};
        end
        mem[`REG_COUNT - 1] = {3'b110, 2'b10, 3'(`REG_COUNT - 1), DATA_BASE};
        for (int i = `REG_COUNT; i < PROG_LEN - 1; i++) begin
            mem[i] = random_inst(i);
        end
        mem[PROG_LEN - 1] = {3'b111, 13'b0};
        for (int a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            model_mem[a] = mem[a];
        end
    endtask

    // instruction-level model of the program that runs ahead of the DUT
    task automatic run_model();
        mem_addr_t  pc;
        mem_addr_t  addr;
        word_t      inst;
        word_t      b;
        word_t      diff;
        int         sdiff;
        logic [2:0] rn;
        logic [2:0] rd;
        logic [2:0] rm;
        logic       taken;
        logic       done;
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        pc          = mem_addr_t'(`RESET_PC);
        model_flags = '0;
        done        = 1'b0;
        while (!done) begin
            inst = model_mem[pc];
            exp_fetch.push_back(pc);
            pc   = pc + mem_addr_t'(1);
            rn   = inst[10:8];
            rd   = inst[7:5];
            rm   = inst[2:0];
            b    = shift_word(model_regs[rm], inst[4:3]);
            addr = mem_addr_t'(model_regs[rn] + {{11{inst[4]}}, inst[4:0]});
            case (inst[15:13])
                3'b110: begin
                    if (inst[12:11] == 2'b10) begin
                        model_regs[rn] = {{8{inst[7]}}, inst[7:0]};
                    end else begin
                        model_regs[rd] = b;
                    end
                end
                3'b101: begin
                    case (inst[12:11])
                        2'b00: model_regs[rd] = model_regs[rn] + b;
                        2'b01: begin
                            diff          = model_regs[rn] - b;
                            sdiff         = int'($signed(model_regs[rn])) - int'($signed(b));
                            model_flags.n = diff[15];
                            model_flags.z = (diff == 16'h0);
                            // true difference outside the signed 16-bit range
                            model_flags.v = (sdiff > 32767) || (sdiff < -32768);
                        end
                        2'b10:   model_regs[rd] = model_regs[rn] & b;
                        default: model_regs[rd] = ~b;
                    endcase
                end
                3'b011: model_regs[rd] = model_mem[addr];
                3'b100: begin
                    model_mem[addr] = model_regs[rd];
                    exp_store_addr.push_back(addr);
                    exp_store_data.push_back(model_regs[rd]);
                end
                3'b001: begin
                    case (rn)
                        3'd0:    taken = 1'b1;
                        3'd1:    taken = model_flags.z;
                        3'd2:    taken = !model_flags.z;
                        3'd3:    taken = (model_flags.n != model_flags.v);
                        3'd4:    taken = (model_flags.n != model_flags.v) || model_flags.z;
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        pc = pc + {inst[7], inst[7:0]};
                    end
                end
                default: done = 1'b1;
            endcase
        end
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_fetch(mem_addr_t got);
        if (exp_fetch.size() == 0) begin
            abort_run($sformatf("fetch from address %h after the program should have halted", got));
        end else if (got !== exp_fetch[0]) begin
            abort_run($sformatf("FAIL %0t: mem_addr (fetch) expected %h got %h",
                                $time, exp_fetch[0], got));
        end else begin
            void'(exp_fetch.pop_front());
        end
    endtask

    task automatic check_store(mem_addr_t got_addr, word_t got_data);
        if (exp_store_addr.size() == 0) begin
            abort_run($sformatf("memory write to %h that the program never makes", got_addr));
        end else if (got_addr !== exp_store_addr[0]) begin
            abort_run($sformatf("FAIL %0t: mem_addr (store) expected %h got %h",
                                $time, exp_store_addr[0], got_addr));
        end else if (got_data !== exp_store_data[0]) begin
            abort_run($sformatf("FAIL %0t: write_data expected %h got %h",
                                $time, exp_store_data[0], got_data));
        end else begin
            void'(exp_store_addr.pop_front());
            void'(exp_store_data.pop_front());
        end
    endtask

    task automatic check_flags(status_t got);
        if (got !== model_flags) begin
            abort_run($sformatf("FAIL %0t: {n,v,z} expected %b got %b", $time, model_flags, got));
        end
    endtask

    // memory answers a read on the next cycle and the two fetch cycles cover that
    always @(posedge clk) begin
        if (mem_cmd == MEM_READ) begin
            if (!mem_addr[`ADDR_WIDTH-1] && !fetch_active) begin
                check_fetch(mem_addr);
            end
            read_data <= mem[mem_addr];
        end else if (mem_cmd == MEM_WRITE) begin
            check_store(mem_addr, write_data);
            mem[mem_addr] = write_data;
        end
        fetch_active = (mem_cmd == MEM_READ) && !mem_addr[`ADDR_WIDTH-1];
    end

    initial begin
        reset        = 1'b1;
        read_data    = '0;
        fetch_active = 1'b0;
        void'($urandom(32'h739c));
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (!halted) @(negedge clk);
        // any fetch or write in the quiet cycles after halt is caught above
        repeat (4) @(negedge clk);
        if (exp_fetch.size() != 0 || exp_store_addr.size() != 0) begin
            abort_run($sformatf("halted with %0d fetches and %0d stores still expected",
                                exp_fetch.size(), exp_store_addr.size()));
        end else begin
            check_flags(status_t'({n, v, z}));
            $display("** PASS **");
            $finish;
        end
    end

    initial begin
        #((RESET_CYCLES + PROG_LEN * 12 + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("** FAIL **");
        $fatal(1, "watchdog expired before the processor halted");
    end

endmodule

/* project.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/dp_ctrl_if.sv
rtl/inst_decoder.sv
rtl/datapath.sv
rtl/pc_unit.sv
rtl/cpu_controller.sv
rtl/cpu.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

/* rtl/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     read_data,
    output cpu_pkg::mem_cmd_e  mem_cmd,
    output cpu_pkg::mem_addr_t mem_addr,
    output cpu_pkg::word_t     write_data,
    output logic               n,
    output logic               v,
    output logic               z,
    output logic               halted
);
    import cpu_pkg::*;

    opcode_e    opcode;
    logic [1:0] op;
    logic [2:0] cond;
    logic [1:0] alu_op;
    logic [1:0] shift;
    word_t      sximm8;
    word_t      sximm5;
    word_t      c_out;
    reg_num_t   reg_num;
    status_t    status;
    logic       load_ir;
    logic       load_pc;
    logic       take_branch;
    logic       load_addr;
    logic       addr_sel;

    dp_ctrl_if ctrl_bus ();

    inst_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .load_ir   (load_ir),
        .read_data (read_data),
        .ctrl      (ctrl_bus.decoder),
        .opcode    (opcode),
        .op        (op),
        .cond      (cond),
        .alu_op    (alu_op),
        .shift     (shift),
        .sximm8    (sximm8),
        .sximm5    (sximm5),
        .reg_num   (reg_num)
    );

    datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl_bus.datapath),
        .reg_num   (reg_num),
        .alu_op    (alu_op),
        .shift     (shift),
        .sximm8    (sximm8),
        .sximm5    (sximm5),
        .read_data (read_data),
        .c_out     (c_out),
        .status    (status)
    );

    pc_unit u_pc_unit (
        .clk         (clk),
        .reset       (reset),
        .load_pc     (load_pc),
        .take_branch (take_branch),
        .load_addr   (load_addr),
        .addr_sel    (addr_sel),
        .sximm8      (sximm8),
        .c_out       (c_out),
        .mem_addr    (mem_addr)
    );

    cpu_controller u_controller (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .op          (op),
        .cond        (cond),
        .status      (status),
        .ctrl        (ctrl_bus.controller),
        .load_ir     (load_ir),
        .load_pc     (load_pc),
        .take_branch (take_branch),
        .load_addr   (load_addr),
        .addr_sel    (addr_sel),
        .mem_cmd     (mem_cmd),
        .halted      (halted)
    );

    // store data always comes from C
    assign write_data = c_out;
    assign n          = status.n;
    assign v          = status.v;
    assign z          = status.z;

endmodule

/* rtl/cpu_controller.sv */
`timescale 1ns/1ps

module cpu_controller (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_e  opcode,
    input  logic [1:0]        op,
    input  logic [2:0]        cond,
    input  cpu_pkg::status_t  status,
    dp_ctrl_if.controller     ctrl,
    output logic              load_ir,
    output logic              load_pc,
    output logic              take_branch,
    output logic              load_addr,
    output logic              addr_sel,
    output cpu_pkg::mem_cmd_e mem_cmd,
    output logic              halted
);
    import cpu_pkg::*;

    typedef enum logic [4:0] {
        S_RESET,
        S_IF1,
        S_IF2,
        S_UPDATE_PC,
        S_DECODE,
        S_WRITE_IMM,
        S_BRANCH,
        S_HALT,
        S_GET_A,
        S_GET_B,
        S_ALU,
        S_WRITE_REG,
        S_ADDR_CALC,
        S_LOAD_ADDR,
        S_MEM_RD,
        S_MEM_WB,
        S_STR_DATA,
        S_STR_PASS,
        S_STR_SETUP,
        S_STR_WRITE
    } state_e;

    state_e state;
    state_e next_state;
    logic   is_cmp;
    logic   cond_true;

    assign is_cmp = (opcode == OP_ALU) && (op == 2'b01);

    always_comb begin
        case (cond)
            3'b000:  cond_true = 1'b1;
            3'b001:  cond_true = status.z;
            3'b010:  cond_true = !status.z;
            3'b011:  cond_true = (status.n != status.v);
            3'b100:  cond_true = (status.n != status.v) || status.z;
            default: cond_true = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_RESET:     next_state = S_IF1;
            S_IF1:       next_state = S_IF2;
            S_IF2:       next_state = S_UPDATE_PC;
            S_UPDATE_PC: next_state = S_DECODE;
            S_DECODE: begin
                next_state = S_HALT;
                case (opcode)
                    OP_MOVE: begin
                        if (op == 2'b10) begin
                            next_state = S_WRITE_IMM;
                        end else if (op == 2'b00) begin
                            next_state = S_GET_A;
                        end
                    end
                    OP_ALU: next_state = S_GET_A;
                    OP_LOAD, OP_STORE, OP_BRANCH: begin
                        if (op == 2'b00) begin
                            next_state = (opcode == OP_BRANCH) ? S_BRANCH : S_GET_A;
                        end
                    end
                    default: next_state = S_HALT;
                endcase
            end
            S_WRITE_IMM: next_state = S_IF1;
            S_BRANCH:    next_state = S_IF1;
            S_HALT:      next_state = S_HALT;
            S_GET_A: begin
                if (opcode == OP_LOAD || opcode == OP_STORE) begin
                    next_state = S_ADDR_CALC;
                end else begin
                    next_state = S_GET_B;
                end
            end
            S_GET_B:     next_state = S_ALU;
            S_ALU:       next_state = S_WRITE_REG;
            S_WRITE_REG: next_state = S_IF1;
            S_ADDR_CALC: next_state = S_LOAD_ADDR;
            S_LOAD_ADDR: next_state = (opcode == OP_LOAD) ? S_MEM_RD : S_STR_DATA;
            S_MEM_RD:    next_state = S_MEM_WB;
            S_MEM_WB:    next_state = S_IF1;
            S_STR_DATA:  next_state = S_STR_PASS;
            S_STR_PASS:  next_state = S_STR_SETUP;
            S_STR_SETUP: next_state = S_STR_WRITE;
            S_STR_WRITE: next_state = S_IF1;
            default:     next_state = S_RESET;
        endcase
    end

    always_comb begin
        ctrl.load_a      = 1'b0;
        ctrl.load_b      = 1'b0;
        ctrl.load_c      = 1'b0;
        ctrl.load_status = 1'b0;
        ctrl.a_sel       = 1'b0;
        ctrl.b_sel       = 1'b0;
        ctrl.reg_write   = 1'b0;
        ctrl.vsel        = VSEL_ALU;
        ctrl.reg_sel     = SEL_RN;
        load_ir          = 1'b0;
        load_pc          = 1'b0;
        take_branch      = 1'b0;
        load_addr        = 1'b0;
        addr_sel         = 1'b1;
        mem_cmd          = MEM_NONE;
        halted           = 1'b0;
        case (state)
            S_IF1: mem_cmd = MEM_READ;
            S_IF2: begin
                mem_cmd = MEM_READ;
                load_ir = 1'b1;
            end
            S_UPDATE_PC: load_pc = 1'b1;
            S_WRITE_IMM: begin
                ctrl.vsel      = VSEL_IMM;
                ctrl.reg_write = 1'b1;
            end
            S_BRANCH: take_branch = cond_true;
            S_HALT:   halted = 1'b1;
            S_GET_A:  ctrl.load_a = 1'b1;
            S_GET_B: begin
                ctrl.reg_sel = SEL_RM;
                ctrl.load_b  = 1'b1;
            end
            S_ALU: begin
                // mov ignores rn, so A is forced to zero
                ctrl.a_sel       = (opcode == OP_MOVE);
                ctrl.load_c      = !is_cmp;
                ctrl.load_status = is_cmp;
            end
            S_WRITE_REG: begin
                ctrl.reg_sel   = SEL_RD;
                ctrl.reg_write = !is_cmp;
            end
            S_ADDR_CALC: begin
                ctrl.b_sel  = 1'b1;
                ctrl.load_c = 1'b1;
            end
            S_LOAD_ADDR: load_addr = 1'b1;
            S_MEM_RD: begin
                addr_sel = 1'b0;
                mem_cmd  = MEM_READ;
            end
            S_MEM_WB: begin
                addr_sel       = 1'b0;
                mem_cmd        = MEM_READ;
                ctrl.reg_sel   = SEL_RD;
                ctrl.vsel      = VSEL_MEM;
                ctrl.reg_write = 1'b1;
            end
            S_STR_DATA: begin
                ctrl.reg_sel = SEL_RD;
                ctrl.load_b  = 1'b1;
            end
            S_STR_PASS: begin
                ctrl.a_sel  = 1'b1;
                ctrl.load_c = 1'b1;
            end
            S_STR_SETUP: addr_sel = 1'b0;
            S_STR_WRITE: begin
                addr_sel = 1'b0;
                mem_cmd  = MEM_WRITE;
            end
            default: begin
            end
        endcase
    end

endmodule

/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and instruction word width
`define WORD_WIDTH 16

// memory and program counter address width
`define ADDR_WIDTH 9

// number of general registers
`define REG_COUNT 8

// address of the first fetch
`define RESET_PC 0

`endif

/* rtl/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_num_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_WRITE = 2'b01,
        MEM_READ  = 2'b10
    } mem_cmd_e;

    typedef enum logic [2:0] {
        OP_BRANCH = 3'b001,
        OP_LOAD   = 3'b011,
        OP_STORE  = 3'b100,
        OP_ALU    = 3'b101,
        OP_MOVE   = 3'b110,
        OP_HALT   = 3'b111
    } opcode_e;

    // which instruction field names the register
    typedef enum logic [1:0] {
        SEL_RN,
        SEL_RD,
        SEL_RM
    } reg_sel_e;

    // register file write source
    typedef enum logic [1:0] {
        VSEL_ALU,
        VSEL_IMM,
        VSEL_MEM
    } vsel_e;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
    } status_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        reg_num_t   rn;
        reg_num_t   rd;
        logic [1:0] shift;
        reg_num_t   rm;
    } inst_reg_t;

    // rn doubles as the branch condition
    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        reg_num_t   rn;
        logic [7:0] imm8;
    } inst_imm_t;

    typedef union packed {
        inst_reg_t r;
        inst_imm_t i;
    } inst_word_t;

endpackage

/* rtl/datapath.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapath (
    input  logic              clk,
    input  logic              reset,
    dp_ctrl_if.datapath       ctrl,
    input  cpu_pkg::reg_num_t reg_num,
    input  logic [1:0]        alu_op,
    input  logic [1:0]        shift,
    input  cpu_pkg::word_t    sximm8,
    input  cpu_pkg::word_t    sximm5,
    input  cpu_pkg::word_t    read_data,
    output cpu_pkg::word_t    c_out,
    output cpu_pkg::status_t  status
);
    import cpu_pkg::*;

    localparam int MSB = `WORD_WIDTH - 1;

    word_t   regs [`REG_COUNT];
    word_t   a_reg;
    word_t   b_reg;
    word_t   c_reg;
    word_t   read_value;
    word_t   write_value;
    word_t   shifted_b;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    word_t   diff;
    status_t next_status;

    assign read_value = regs[reg_num];

    always_comb begin
        case (ctrl.vsel)
            VSEL_IMM: write_value = sximm8;
            VSEL_MEM: write_value = read_data;
            default:  write_value = c_reg;
        endcase
    end

    always_comb begin
        case (shift)
            2'b01:   shifted_b = {b_reg[MSB-1:0], 1'b0};
            2'b10:   shifted_b = {1'b0, b_reg[MSB:1]};
            2'b11:   shifted_b = {b_reg[MSB], b_reg[MSB:1]};
            default: shifted_b = b_reg;
        endcase
    end

    assign alu_a = ctrl.a_sel ? '0 : a_reg;
    assign alu_b = ctrl.b_sel ? sximm5 : shifted_b;
    assign diff  = alu_a - alu_b;

    always_comb begin
        case (alu_op)
            2'b00:   alu_result = alu_a + alu_b;
            2'b01:   alu_result = diff;
            2'b10:   alu_result = alu_a & alu_b;
            default: alu_result = ~alu_b;
        endcase
    end

    // flags come from the subtraction only
    assign next_status.n = diff[MSB];
    assign next_status.z = (diff == '0);
    assign next_status.v = (alu_a[MSB] != alu_b[MSB]) && (diff[MSB] != alu_a[MSB]);

    always_ff @(posedge clk) begin
        if (ctrl.reg_write) begin
            regs[reg_num] <= write_value;
        end
        if (ctrl.load_a) begin
            a_reg <= read_value;
        end
        if (ctrl.load_b) begin
            b_reg <= read_value;
        end
        if (ctrl.load_c) begin
            c_reg <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (ctrl.load_status) begin
            status <= next_status;
        end
    end

    assign c_out = c_reg;

endmodule

/* rtl/dp_ctrl_if.sv */
`timescale 1ns/1ps

interface dp_ctrl_if;
    import cpu_pkg::*;

    logic     load_a;
    logic     load_b;
    logic     load_c;
    logic     load_status;
    logic     a_sel;
    logic     b_sel;
    logic     reg_write;
    vsel_e    vsel;
    reg_sel_e reg_sel;

    modport controller (
        output load_a, load_b, load_c, load_status, a_sel, b_sel, reg_write, vsel, reg_sel
    );

    modport datapath (
        input load_a, load_b, load_c, load_status, a_sel, b_sel, reg_write, vsel
    );

    modport decoder (
        input reg_sel
    );

endinterface

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module inst_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_ir,
    input  cpu_pkg::word_t    read_data,
    dp_ctrl_if.decoder        ctrl,
    output cpu_pkg::opcode_e  opcode,
    output logic [1:0]        op,
    output logic [2:0]        cond,
    output logic [1:0]        alu_op,
    output logic [1:0]        shift,
    output cpu_pkg::word_t    sximm8,
    output cpu_pkg::word_t    sximm5,
    output cpu_pkg::reg_num_t reg_num
);
    import cpu_pkg::*;

    inst_word_t ir;
    logic [4:0] imm5;
    logic       shift_form;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (load_ir) begin
            ir <= read_data;
        end
    end

    assign opcode = opcode_e'(ir.r.opcode);
    assign op     = ir.r.op;
    assign cond   = ir.i.rn;

    // mov forms always pass through the adder
    assign alu_op = (opcode == OP_MOVE) ? 2'b00 : ir.r.op;

    // only register-form mov and alu instructions carry a shift
    assign shift_form = (opcode == OP_ALU) || (opcode == OP_MOVE && ir.r.op == 2'b00);
    assign shift      = shift_form ? ir.r.shift : 2'b00;

    // imm5 overlays the shift and rm fields
    assign imm5   = {ir.r.shift, ir.r.rm};
    assign sximm8 = {{(`WORD_WIDTH-8){ir.i.imm8[7]}}, ir.i.imm8};
    assign sximm5 = {{(`WORD_WIDTH-5){imm5[4]}}, imm5};

    always_comb begin
        case (ctrl.reg_sel)
            SEL_RD:  reg_num = ir.r.rd;
            SEL_RM:  reg_num = ir.r.rm;
            default: reg_num = ir.r.rn;
        endcase
    end

endmodule

/* rtl/pc_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module pc_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_pc,
    input  logic               take_branch,
    input  logic               load_addr,
    input  logic               addr_sel,
    input  cpu_pkg::word_t     sximm8,
    input  cpu_pkg::word_t     c_out,
    output cpu_pkg::mem_addr_t mem_addr
);
    import cpu_pkg::*;

    mem_addr_t pc;
    mem_addr_t next_pc;
    mem_addr_t data_addr;

    // branch offset is relative to the already incremented pc
    always_comb begin
        next_pc = pc;
        if (take_branch) begin
            next_pc = pc + sximm8[`ADDR_WIDTH-1:0];
        end else if (load_pc) begin
            next_pc = pc + mem_addr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mem_addr_t'(`RESET_PC);
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (load_addr) begin
            data_addr <= c_out[`ADDR_WIDTH-1:0];
        end
    end

    assign mem_addr = addr_sel ? pc : data_addr;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb \
    -f project.f -Mdir obj_dir -o cpu_sim

./obj_dir/cpu_sim
